//--- list.f
+incdir+tb
common/scram_pkg.sv
scram/scram.sv
source/axil_decode.sv
source/axil_result.sv
source/scram_axil_top.sv
tb/tb_scram_axil.sv

//--- Bender.yml
package:
  name: scram_axil

sources:
  - common/scram_pkg.sv
  - scram/scram.sv
  - source/axil_decode.sv
  - source/axil_result.sv
  - source/scram_axil_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_scram_axil.sv

//--- tb/tb_axil_tasks.svh
//##############################
// AXI4-Lite driver tasks, value check and reference memory model,
// included into the testbench module body
//##############################

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Expected RAM words and handshake edge times per port and direction
data_t ref_mem   [NUM_WORDS];
time   addr_time [2][2];
time   resp_time [2][2];

task automatic check_value(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
        $display("mismatch %s: got %h, expected %h", name, actual, expected);
        mismatches++;
    end
endtask

function automatic void ref_write(input axil_addr_t addr, input data_t data, input strb_t strb);
    word_addr_t word;
    word = addr[WORD_AW+WORD_LSB-1:WORD_LSB];
    for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) begin
            ref_mem[word][i*8 +: 8] = data[i*8 +: 8];
        end
    end
endfunction

// Port 1 owns the bytes both strobes touch on a shared word
function automatic void ref_dual_write(input axil_addr_t addr, input data_t d1, input strb_t s1,
                                       input data_t d2, input strb_t s2);
    ref_write(addr, d2, s2);
    ref_write(addr, d1, s1);
endfunction

function automatic bit flag_of(input int port, input string name);
    axil_rsp_t rsp;
    rsp = s_rsp[port-1];
    case (name)
        "awready": return rsp.awready && rsp.wready;
        "arready": return rsp.arready;
        "bvalid":  return rsp.bvalid;
        default:   return rsp.rvalid;
    endcase
endfunction

task automatic wait_flag(input int port, input string name, output bit ok);
    int n;
    n = 0;
    @(negedge aclk);
    while (!flag_of(port, name) && n < MAX_WAIT) begin
        n++;
        @(negedge aclk);
    end
    ok = flag_of(port, name);
    if (!ok) begin
        $display("timeout: port %0d did not raise %s within %0d cycles", port, name, MAX_WAIT);
        timeouts++;
    end
endtask

// One write or read on a port with the response ready held low for hold cycles
task automatic axil_xfer(input int port, input bit rd, input axil_addr_t addr,
                         input data_t wdata, input strb_t strb, input int hold,
                         output data_t rdata, output resp_t resp);
    int    p;
    bit    ok;
    string vname;
    p = port - 1;
    vname = rd ? "rvalid" : "bvalid";
    @(posedge aclk);
    if (rd) begin
        s_req[p].arvalid <= 1'b1;
        s_req[p].araddr  <= addr;
    end else begin
        s_req[p].awvalid <= 1'b1;
        s_req[p].awaddr  <= addr;
        s_req[p].wvalid  <= 1'b1;
        s_req[p].wdata   <= wdata;
        s_req[p].wstrb   <= strb;
    end
    wait_flag(port, rd ? "arready" : "awready", ok);
    @(posedge aclk);
    addr_time[p][rd] = $time;
    if (rd) begin
        s_req[p].arvalid <= 1'b0;
    end else begin
        s_req[p].awvalid <= 1'b0;
        s_req[p].wvalid  <= 1'b0;
    end
    if (ok) begin
        wait_flag(port, vname, ok);
    end
    rdata = s_rsp[p].rdata;
    resp  = rd ? s_rsp[p].rresp : s_rsp[p].bresp;
    if (!ok) begin
        return;
    end
    // Stalled master sees a frozen response and no new address accepted
    repeat (hold) begin
        @(negedge aclk);
        check_value($sformatf("s%0d.%s", port, vname), flag_of(port, vname), 1);
        check_value($sformatf("s%0d.%s", port, rd ? "rresp" : "bresp"),
                    rd ? s_rsp[p].rresp : s_rsp[p].bresp, resp);
        check_value($sformatf("s%0d.rdata", port), s_rsp[p].rdata, rdata);
        check_value($sformatf("s%0d.awready", port), s_rsp[p].awready, 0);
        check_value($sformatf("s%0d.wready", port), s_rsp[p].wready, 0);
        check_value($sformatf("s%0d.arready", port), s_rsp[p].arready, 0);
    end
    @(posedge aclk);
    s_req[p].bready <= !rd;
    s_req[p].rready <= rd;
    @(posedge aclk);
    resp_time[p][rd] = $time;
    s_req[p].bready <= 1'b0;
    s_req[p].rready <= 1'b0;
endtask

`endif

//--- tb/tb_scram_axil.sv
//##############################
// Directed testbench for the two-port AXI4-Lite scratch memory
//##############################

module tb_scram_axil
    import scram_pkg::*;
();

    localparam int MAX_WAIT = 100;

    logic      aclk;
    logic      arst_n;
    axil_req_t s_req [2];
    axil_rsp_t s_rsp [2];
    int        mismatches;
    int        timeouts;

    `include "tb_axil_tasks.svh"

    scram_axil_top i_dut (
        .aclk   (aclk),
        .arst_n (arst_n),
        .s1_req (s_req[0]),
        .s1_rsp (s_rsp[0]),
        .s2_req (s_req[1]),
        .s2_rsp (s_rsp[1])
    );

    always #20 aclk = ~aclk;

    task automatic write_ok(input int port, input axil_addr_t addr, input data_t data,
                            input strb_t strb);
        data_t unused;
        resp_t resp;
        axil_xfer(port, 1'b0, addr, data, strb, 0, unused, resp);
        check_value($sformatf("s%0d.bresp", port), resp, RESP_OKAY);
        ref_write(addr, data, strb);
    endtask

    task automatic read_ok(input int port, input axil_addr_t addr);
        data_t data;
        resp_t resp;
        axil_xfer(port, 1'b1, addr, '0, '0, 0, data, resp);
        check_value($sformatf("s%0d.rresp", port), resp, RESP_OKAY);
        check_value($sformatf("s%0d.rdata", port), data,
                    ref_mem[addr[WORD_AW+WORD_LSB-1:WORD_LSB]]);
    endtask

    task automatic test_single();
        write_ok(1, 12'h000, 32'h0123_4567, 4'hf);
        read_ok(1, 12'h000);
        write_ok(2, 12'h004, 32'h89ab_cdef, 4'hf);
        read_ok(2, 12'h004);
    endtask

    task automatic test_partial();
        write_ok(1, 12'h040, 32'hffff_ffff, 4'hf);
        write_ok(1, 12'h040, 32'h1234_5678, 4'b1010);
        read_ok(1, 12'h040);
        write_ok(2, 12'h044, 32'h0000_0000, 4'hf);
        write_ok(2, 12'h044, 32'hcafe_f00d, 4'b0001);
        read_ok(2, 12'h044);
    endtask

    task automatic test_cross();
        write_ok(1, 12'h100, 32'h1111_2222, 4'hf);
        read_ok(2, 12'h100);
        write_ok(2, 12'h3fc, 32'h3333_4444, 4'hf);
        read_ok(1, 12'h3fc);
    endtask

    // Both ports hit one word on the same edge, byte 1 overlaps
    task automatic test_same_word();
        data_t unused;
        resp_t r1;
        resp_t r2;
        write_ok(1, 12'h080, 32'h0000_0000, 4'hf);
        fork
            axil_xfer(1, 1'b0, 12'h080, 32'h1122_3344, 4'b0110, 0, unused, r1);
            axil_xfer(2, 1'b0, 12'h080, 32'haabb_ccdd, 4'b0011, 0, unused, r2);
        join
        check_value("s1.bresp", r1, RESP_OKAY);
        check_value("s2.bresp", r2, RESP_OKAY);
        ref_dual_write(12'h080, 32'h1122_3344, 4'b0110, 32'haabb_ccdd, 4'b0011);
        read_ok(1, 12'h080);
        read_ok(2, 12'h080);
    endtask

    task automatic test_range();
        data_t data;
        resp_t resp;
        write_ok(1, 12'h008, 32'h5555_aaaa, 4'hf);
        axil_xfer(1, 1'b0, 12'h408, 32'hdead_beef, 4'hf, 0, data, resp);
        check_value("s1.bresp", resp, RESP_SLVERR);
        axil_xfer(2, 1'b1, 12'h400, '0, '0, 0, data, resp);
        check_value("s2.rresp", resp, RESP_SLVERR);
        check_value("s2.rdata", data, '0);
        read_ok(2, 12'h008);
        read_ok(1, 12'h000);
    endtask

    // Stalls one response while the opposite direction waits on the same port
    task automatic test_stall(input int port, input bit rd);
        data_t old_word;
        data_t d1;
        data_t d2;
        resp_t r1;
        resp_t r2;
        bit    ok;
        write_ok(port, 12'h0c0, 32'h5a5a_0f0f ^ port, 4'hf);
        old_word = ref_mem[8'h30];
        fork
            axil_xfer(port, rd, 12'h0c0, 32'h0f0f_5a5a, 4'hf, 1 + $urandom % 20, d1, r1);
            begin
                wait_flag(port, rd ? "rvalid" : "bvalid", ok);
                axil_xfer(port, !rd, 12'h0c0, 32'h0f0f_5a5a, 4'hf, 0, d2, r2);
            end
        join
        ref_write(12'h0c0, 32'h0f0f_5a5a, 4'hf);
        check_value($sformatf("s%0d.bresp", port), rd ? r2 : r1, RESP_OKAY);
        check_value($sformatf("s%0d.rresp", port), rd ? r1 : r2, RESP_OKAY);
        check_value($sformatf("s%0d.rdata", port), rd ? d1 : d2,
                    rd ? old_word : ref_mem[8'h30]);
        check_value($sformatf("s%0d.%s", port, rd ? "awready" : "arready"),
                    addr_time[port-1][!rd] > resp_time[port-1][rd], 1);
    endtask

    initial begin
        void'($urandom(32'hc59));
        aclk       = 1'b0;
        arst_n     = 1'b0;
        s_req[0]   = '0;
        s_req[1]   = '0;
        mismatches = 0;
        timeouts   = 0;
        repeat (16) @(posedge aclk);
        arst_n <= 1'b1;
        test_single();
        test_partial();
        test_cross();
        test_same_word();
        test_range();
        test_stall(1, 1'b0);
        test_stall(2, 1'b1);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- source/scram_axil_top.sv
//##############################
// Two AXI4-Lite slave ports sharing one scratch RAM
//##############################

module scram_axil_top
    import scram_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  axil_req_t s1_req,
    output axil_rsp_t s1_rsp,
    input  axil_req_t s2_req,
    output axil_rsp_t s2_rsp
);

    mem_req_t mem_req1;
    mem_req_t mem_req2;
    mem_rsp_t mem_rsp1;
    mem_rsp_t mem_rsp2;
    pend_t    pend1;
    pend_t    pend2;
    logic     done1;
    logic     done2;

    // Port 1
    axil_decode u_dec1 (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .axi_req   (s1_req),
        .awready   (s1_rsp.awready),
        .wready    (s1_rsp.wready),
        .arready   (s1_rsp.arready),
        .mem_req   (mem_req1),
        .pend      (pend1),
        .mem_ready (mem_rsp1.ready),
        .done      (done1)
    );

    axil_result u_res1 (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .pend    (pend1),
        .mem_rsp (mem_rsp1),
        .bready  (s1_req.bready),
        .rready  (s1_req.rready),
        .bvalid  (s1_rsp.bvalid),
        .bresp   (s1_rsp.bresp),
        .rvalid  (s1_rsp.rvalid),
        .rdata   (s1_rsp.rdata),
        .rresp   (s1_rsp.rresp),
        .done    (done1)
    );

    // Port 2
    axil_decode u_dec2 (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .axi_req   (s2_req),
        .awready   (s2_rsp.awready),
        .wready    (s2_rsp.wready),
        .arready   (s2_rsp.arready),
        .mem_req   (mem_req2),
        .pend      (pend2),
        .mem_ready (mem_rsp2.ready),
        .done      (done2)
    );

    axil_result u_res2 (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .pend    (pend2),
        .mem_rsp (mem_rsp2),
        .bready  (s2_req.bready),
        .rready  (s2_req.rready),
        .bvalid  (s2_rsp.bvalid),
        .bresp   (s2_rsp.bresp),
        .rvalid  (s2_rsp.rvalid),
        .rdata   (s2_rsp.rdata),
        .rresp   (s2_rsp.rresp),
        .done    (done2)
    );

    scram u_ram (
        .aclk   (aclk),
        .arst_n (arst_n),
        .p1_req (mem_req1),
        .p1_rsp (mem_rsp1),
        .p2_req (mem_req2),
        .p2_rsp (mem_rsp2)
    );

endmodule

//--- source/axil_result.sv
//##############################
// Response side of one AXI4-Lite port: builds B or R from the RAM
// answer and holds it until the master takes it
//##############################

module axil_result
    import scram_pkg::*;
(
    input  logic     aclk,
    input  logic     arst_n,
    input  pend_t    pend,
    input  mem_rsp_t mem_rsp,
    input  logic     bready,
    input  logic     rready,
    output logic     bvalid,
    output resp_t    bresp,
    output logic     rvalid,
    output data_t    rdata,
    output resp_t    rresp,
    output logic     done
);

    logic  capture;
    resp_t resp_q;
    data_t rdata_q;

    // Errors answer at once, good accesses wait for the RAM
    assign capture = pend.valid && !bvalid && !rvalid &&
                     (pend.err || mem_rsp.ready);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else if (capture) begin
            bvalid <= pend.wr;
            rvalid <= !pend.wr;
        end else if (done) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end
    end

    // Response stays frozen while valid is up
    always_ff @(posedge aclk) begin
        if (capture) begin
            if (pend.err) begin
                resp_q  <= RESP_SLVERR;
                rdata_q <= '0;
            end else begin
                resp_q  <= RESP_OKAY;
                rdata_q <= mem_rsp.rdata;
            end
        end
    end

    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

    // B or R handshake closes the transaction
    assign done = (bvalid && bready) || (rvalid && rready);

endmodule

//--- source/axil_decode.sv
//##############################
// Request side of one AXI4-Lite port: accepts one write or read,
// checks the range and holds the RAM request until it is served
//##############################

module axil_decode
    import scram_pkg::*;
(
    input  logic      aclk,
    input  logic      arst_n,
    input  axil_req_t axi_req,
    output logic      awready,
    output logic      wready,
    output logic      arready,
    output mem_req_t  mem_req,
    output pend_t     pend,
    input  logic      mem_ready,
    input  logic      done
);

    dec_state_t state;
    dec_state_t state_nxt;

    logic wr_offer;
    logic rd_offer;
    logic take_wr;
    logic take_rd;
    logic wr_first;

    // Latched transaction
    word_addr_t addr_q;
    data_t      wdata_q;
    strb_t      strb_q;
    logic       wr_q;
    logic       err_q;

    axil_addr_t byte_addr;

    // Write needs both AW and W present, taken as one transfer
    assign wr_offer = axi_req.awvalid && axi_req.wvalid;
    assign rd_offer = axi_req.arvalid;

    // Alternate grants when both directions are waiting
    assign take_wr = (state == IDLE) && wr_offer && (wr_first || !rd_offer);
    assign take_rd = (state == IDLE) && rd_offer && !take_wr;

    assign awready = take_wr;
    assign wready  = take_wr;
    assign arready = take_rd;

    assign byte_addr = take_wr ? axi_req.awaddr : axi_req.araddr;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (take_wr || take_rd) begin
                    state_nxt = ISSUE;
                end
            end
            ISSUE: begin
                // Out of range requests bypass the RAM
                if (err_q || mem_ready) begin
                    state_nxt = WAIT_RESULT;
                end
            end
            WAIT_RESULT: begin
                if (done) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            wr_first <= 1'b1;
        end else begin
            state <= state_nxt;
            if (take_wr) begin
                wr_first <= 1'b0;
            end else if (take_rd) begin
                wr_first <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take_wr || take_rd) begin
            addr_q  <= byte_addr[WORD_AW+WORD_LSB-1:WORD_LSB];
            wdata_q <= axi_req.wdata;
            strb_q  <= axi_req.wstrb;
            wr_q    <= take_wr;
            // Anything above the 1 KiB window
            err_q   <= |byte_addr[ADDR_W-1:WORD_AW+WORD_LSB];
        end
    end

    assign mem_req.en    = (state == ISSUE) && !err_q;
    assign mem_req.wr    = wr_q;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = wdata_q;
    assign mem_req.strb  = strb_q;

    assign pend.valid = (state == ISSUE);
    assign pend.wr    = wr_q;
    assign pend.err   = err_q;

endmodule

//--- scram/scram.sv
//##############################
// Dual-port 256 x 32 scratch RAM with byte strobes, registered
// read data and a ready flag per port
//##############################

module scram
    import scram_pkg::*;
(
    input  logic     aclk,
    input  logic     arst_n,
    input  mem_req_t p1_req,
    output mem_rsp_t p1_rsp,
    input  mem_req_t p2_req,
    output mem_rsp_t p2_rsp
);

    data_t ram [NUM_WORDS];

    mem_req_t port_req [2];
    data_t    rdata_q  [2];
    logic     ready_q  [2];
    strb_t    wr_strb  [2];
    logic     same_word_wr;

    assign port_req[0] = p1_req;
    assign port_req[1] = p2_req;

    // Both ports writing one word in the same cycle
    assign same_word_wr = p1_req.en && p1_req.wr && p2_req.en && p2_req.wr &&
                          (p1_req.addr == p2_req.addr);

    always_comb begin
        wr_strb[0] = (p1_req.en && p1_req.wr) ? p1_req.strb : '0;
        wr_strb[1] = (p2_req.en && p2_req.wr) ? p2_req.strb : '0;
        // Port 1 owns any byte both ports touch
        if (same_word_wr) begin
            wr_strb[1] = p2_req.strb & ~p1_req.strb;
        end
    end

    // Strobes never overlap here, so the two writes cannot collide
    always_ff @(posedge aclk) begin
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[p][i]) begin
                    ram[port_req[p].addr][i*8 +: 8] <= port_req[p].wdata[i*8 +: 8];
                end
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port

        // Old word contents, written values show up one access later
        always_ff @(posedge aclk) begin
            if (port_req[p].en) begin
                rdata_q[p] <= ram[port_req[p].addr];
            end
        end

        // Toggles so a held read sees ready on its second cycle
        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                ready_q[p] <= 1'b0;
            end else begin
                ready_q[p] <= port_req[p].en && !ready_q[p];
            end
        end

    end

    assign p1_rsp.rdata = rdata_q[0];
    assign p1_rsp.ready = p1_req.en && (p1_req.wr || ready_q[0]);

    assign p2_rsp.rdata = rdata_q[1];
    assign p2_rsp.ready = p2_req.en && (p2_req.wr || ready_q[1]);

endmodule

//--- common/scram_pkg.sv
//##############################
// Widths, bus structs and FSM encoding shared by the scratch memory
// and its AXI4-Lite ports; modules import it in their header
//##############################

package scram_pkg;

    // AXI byte address and data widths
    localparam int ADDR_W  = 12;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;

    // RAM geometry, byte address bits 9:2 select the word
    localparam int WORD_AW   = 8;
    localparam int WORD_LSB  = 2;
    localparam int NUM_WORDS = 2 ** WORD_AW;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic [ADDR_W-1:0]  axil_addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [WORD_AW-1:0] word_addr_t;
    typedef logic [1:0]         resp_t;

    // Master side of one AXI4-Lite port
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        data_t      wdata;
        strb_t      wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Slave side of one AXI4-Lite port
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic       en;
        logic       wr;
        word_addr_t addr;
        data_t      wdata;
        strb_t      strb;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  ready;
    } mem_rsp_t;

    // Handed from decode to result while a request is in flight
    typedef struct packed {
        logic valid;
        logic wr;
        logic err;
    } pend_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_RESULT
    } dec_state_t;

endpackage
